//--- source/biu_ahb_pkg.sv
// shared BIU/AHB-Lite codes; biu_type_e and hburst_e share one numbering, structs carry no address/data
package biu_ahb_pkg;

  //////////////////////////////////////////////////////////////////////
  // core side codes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    BIU_BYTE  = 3'b000,
    BIU_HWORD = 3'b001,
    BIU_WORD  = 3'b010,
    BIU_DWORD = 3'b011   // only meaningful with XLEN 64
  } biu_size_e;

  typedef enum logic [2:0] {
    BIU_SINGLE = 3'b000,
    BIU_INCR   = 3'b001, // undefined length, issued as one beat
    BIU_WRAP4  = 3'b010,
    BIU_INCR4  = 3'b011,
    BIU_WRAP8  = 3'b100,
    BIU_INCR8  = 3'b101,
    BIU_WRAP16 = 3'b110,
    BIU_INCR16 = 3'b111
  } biu_type_e;

  // masks inside the 3 bit core protection code
  localparam logic [2:0] PROT_DATA       = 3'b001; // clear means opcode fetch
  localparam logic [2:0] PROT_PRIVILEGED = 3'b010; // clear means user
  localparam logic [2:0] PROT_CACHEABLE  = 3'b100;

  //////////////////////////////////////////////////////////////////////
  // AHB-Lite codes
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01, // never issued, master does not stall bursts
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001,
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } hburst_e;

  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_e;

  // hsize encodings
  localparam logic [2:0] HSIZE_BYTE  = 3'b000;
  localparam logic [2:0] HSIZE_HWORD = 3'b001;
  localparam logic [2:0] HSIZE_WORD  = 3'b010;
  localparam logic [2:0] HSIZE_DWORD = 3'b011;

  // hprot bit values, the "off" values are zero
  localparam logic [3:0] HPROT_OPCODE         = 4'b0000;
  localparam logic [3:0] HPROT_DATA           = 4'b0001;
  localparam logic [3:0] HPROT_USER           = 4'b0000;
  localparam logic [3:0] HPROT_PRIVILEGED     = 4'b0010;
  localparam logic [3:0] HPROT_NON_BUFFERABLE = 4'b0000;
  localparam logic [3:0] HPROT_NON_CACHEABLE  = 4'b0000;
  localparam logic [3:0] HPROT_CACHEABLE      = 4'b1000;

  // data, privileged, non-bufferable, non-cacheable
  localparam logic [3:0] HPROT_RESET = HPROT_DATA | HPROT_PRIVILEGED |
                                       HPROT_NON_BUFFERABLE | HPROT_NON_CACHEABLE;

  //////////////////////////////////////////////////////////////////////
  // stage structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       hwrite;
    logic [2:0] hsize;
    hburst_e    hburst;
    logic [3:0] hprot;
    logic       hmastlock;
  } ahb_ctrl_t;   // 12 bits

  typedef struct packed {
    ahb_ctrl_t  ctrl;
    logic [3:0] beats_m1;  // beat count minus one
  } biu_cmd_t;    // 16 bits

endpackage

//--- source/biu_req_decode.sv
// purely combinational; size codes above DWORD fall back to a byte transfer, INCR is one beat
module biu_req_decode
  import biu_ahb_pkg::*;
(
  input  biu_size_e  biu_size_i,
  input  biu_type_e  biu_type_i,
  input  logic [2:0] biu_prot_i,
  input  logic       biu_lock_i,
  input  logic       biu_we_i,
  output biu_cmd_t   cmd_o
);

  //////////////////////////////////////////////////////////////////////
  // code mapping
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cmd_o.ctrl.hwrite    = biu_we_i;
    cmd_o.ctrl.hmastlock = biu_lock_i;

    // transfer size
    case (biu_size_i)
      BIU_BYTE:  cmd_o.ctrl.hsize = HSIZE_BYTE;
      BIU_HWORD: cmd_o.ctrl.hsize = HSIZE_HWORD;
      BIU_WORD:  cmd_o.ctrl.hsize = HSIZE_WORD;
      BIU_DWORD: cmd_o.ctrl.hsize = HSIZE_DWORD;
      default:   cmd_o.ctrl.hsize = HSIZE_BYTE;   // unknown code, keep it harmless
    endcase

    // burst type
    case (biu_type_i)
      BIU_SINGLE: cmd_o.ctrl.hburst = HBURST_SINGLE;
      BIU_INCR:   cmd_o.ctrl.hburst = HBURST_INCR;
      BIU_WRAP4:  cmd_o.ctrl.hburst = HBURST_WRAP4;
      BIU_INCR4:  cmd_o.ctrl.hburst = HBURST_INCR4;
      BIU_WRAP8:  cmd_o.ctrl.hburst = HBURST_WRAP8;
      BIU_INCR8:  cmd_o.ctrl.hburst = HBURST_INCR8;
      BIU_WRAP16: cmd_o.ctrl.hburst = HBURST_WRAP16;
      BIU_INCR16: cmd_o.ctrl.hburst = HBURST_INCR16;
      default:    cmd_o.ctrl.hburst = HBURST_SINGLE;   // X on the type input, single beat
    endcase

    // beats per burst minus one
    case (biu_type_i)
      BIU_WRAP4, BIU_INCR4:   cmd_o.beats_m1 = 4'd3;
      BIU_WRAP8, BIU_INCR8:   cmd_o.beats_m1 = 4'd7;
      BIU_WRAP16, BIU_INCR16: cmd_o.beats_m1 = 4'd15;
      default:                cmd_o.beats_m1 = 4'd0;    // SINGLE, INCR or unknown
    endcase

    // protection, one bit at a time
    cmd_o.ctrl.hprot = (|(biu_prot_i & PROT_DATA)) ? HPROT_DATA : HPROT_OPCODE;
    cmd_o.ctrl.hprot = cmd_o.ctrl.hprot |
                       ((|(biu_prot_i & PROT_PRIVILEGED)) ? HPROT_PRIVILEGED : HPROT_USER);
    cmd_o.ctrl.hprot = cmd_o.ctrl.hprot |
                       ((|(biu_prot_i & PROT_CACHEABLE)) ? HPROT_CACHEABLE
                                                         : HPROT_NON_CACHEABLE);
  end

endmodule

//--- source/ahb_addr_phase.sv
// XLEN must be 32 or 64; bursts never insert BUSY and an ERROR seen with hready low aborts them
module ahb_addr_phase
  import biu_ahb_pkg::*;
#(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic            HCLK,
  input  logic            HRESETn,

  // core side
  input  logic            biu_stb_i,
  input  logic [PLEN-1:0] biu_adri_i,
  input  biu_cmd_t        cmd_i,       // from request decode
  output logic            biu_stb_ack_o,
  output logic            biu_d_ack_o,

  // AHB-Lite address phase
  input  logic            hready_i,
  input  hresp_e          hresp_i,
  output logic            hsel_o,
  output logic [PLEN-1:0] haddr_o,
  output htrans_e         htrans_o,
  output ahb_ctrl_t       ctrl_o,

  // to data stage
  output logic            data_ena_o,  // a beat sits in the address phase
  output logic            err_o        // one-cycle abort pulse
);

  localparam int STEP = XLEN / 8;      // bytes per beat

  logic [3:0] burst_cnt;               // beats left after the current one

  //////////////////////////////////////////////////////////////////////
  // next burst address
  //////////////////////////////////////////////////////////////////////

  function automatic logic [PLEN-1:0] nxt_addr(input logic [PLEN-1:0] addr,
                                               input hburst_e         hburst);
    logic [PLEN-1:0] lin;   // linear step, aligned to the beat
    logic [PLEN-1:0] wmask; // offset bits inside the wrap block
    lin = (addr + PLEN'(STEP)) & ~PLEN'(STEP - 1);
    case (hburst)
      HBURST_WRAP4:  wmask = PLEN'(4 * STEP - 1);
      HBURST_WRAP8:  wmask = PLEN'(8 * STEP - 1);
      HBURST_WRAP16: wmask = PLEN'(16 * STEP - 1);
      default:       wmask = '1;       // incrementing, take all bits
    endcase
    return (addr & ~wmask) | (lin & wmask); // upper bits stay for wraps
  endfunction

  //////////////////////////////////////////////////////////////////////
  // address phase registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      burst_cnt  <= 4'd0;
      data_ena_o <= 1'b0;
      err_o      <= 1'b0;
      hsel_o     <= 1'b0;
      haddr_o    <= '0;
      htrans_o   <= HTRANS_IDLE;
      ctrl_o     <= '{hwrite: 1'b0, hsize: HSIZE_BYTE, hburst: HBURST_SINGLE,
                      hprot: HPROT_RESET, hmastlock: 1'b0};
    end else begin
      err_o <= 1'b0;                   // pulse only

      if (hready_i) begin
        if (burst_cnt == 4'd0) begin
          // idle or last beat issued, may start a new request
          if (biu_stb_i && !err_o) begin
            burst_cnt  <= cmd_i.beats_m1;
            data_ena_o <= 1'b1;
            hsel_o     <= 1'b1;
            haddr_o    <= biu_adri_i;
            htrans_o   <= HTRANS_NONSEQ;  // first beat
            ctrl_o     <= cmd_i.ctrl;
          end else begin
            data_ena_o       <= 1'b0;
            hsel_o           <= 1'b0;
            htrans_o         <= HTRANS_IDLE;
            ctrl_o.hmastlock <= cmd_i.ctrl.hmastlock; // lock may be held between transfers
          end
        end else begin
          // burst in progress
          burst_cnt  <= burst_cnt - 4'd1;
          data_ena_o <= 1'b1;
          htrans_o   <= HTRANS_SEQ;
          haddr_o    <= nxt_addr(haddr_o, ctrl_o.hburst);
        end
      end else if (hresp_i == HRESP_ERROR) begin
        // first cycle of the two-cycle error response, drop the rest
        burst_cnt  <= 4'd0;
        data_ena_o <= 1'b0;
        hsel_o     <= 1'b0;
        htrans_o   <= HTRANS_IDLE;
        err_o      <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // core handshakes
  //////////////////////////////////////////////////////////////////////

  // new strobe only between bursts and never in the error pulse cycle
  assign biu_stb_ack_o = hready_i & (burst_cnt == 4'd0) & biu_stb_i & ~err_o;
  assign biu_d_ack_o   = hready_i & data_ena_o;  // core moves to next write datum

endmodule

//--- source/ahb_data_phase.sv
// write data is taken once per hready edge; read data and hready are passed on unregistered
module ahb_data_phase
  import biu_ahb_pkg::*;
#(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic            HCLK,
  input  logic            HRESETn,

  input  logic            hready_i,
  input  logic            data_ena_i,  // beat in address phase
  input  logic [PLEN-1:0] haddr_i,     // its address

  // core data
  input  logic [XLEN-1:0] biu_d_i,
  output logic [XLEN-1:0] biu_q_o,
  output logic [PLEN-1:0] biu_adro_o,
  output logic            biu_ack_o,

  // AHB-Lite data phase
  input  logic [XLEN-1:0] hrdata_i,
  output logic [XLEN-1:0] hwdata_o
);

  logic data_ena_d;                    // a beat sits in the data phase

  //////////////////////////////////////////////////////////////////////
  // data phase tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      data_ena_d <= 1'b0;
    end else if (hready_i) begin
      data_ena_d <= data_ena_i;        // follows the address phase by one beat
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////////////////////////

  // datum of the beat leaving the address phase goes onto hwdata
  always_ff @(posedge HCLK) begin
    if (hready_i) begin
      hwdata_o   <= biu_d_i;
      biu_adro_o <= haddr_i;           // address of the beat now in data phase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // core outputs
  //////////////////////////////////////////////////////////////////////

  assign biu_q_o   = hrdata_i;                // valid with biu_ack_o on reads
  assign biu_ack_o = hready_i & data_ena_d;   // data phase done

endmodule

//--- source/biu_ahb_master.sv
// AHB-Lite master port only, no bridge below; XLEN 32 or 64, hsel/hready are single-slave style
module biu_ahb_master
  import biu_ahb_pkg::*;
#(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic            HCLK,
  input  logic            HRESETn,

  // BIU core port
  input  logic            biu_stb_i,     // held until biu_stb_ack_o
  output logic            biu_stb_ack_o,
  output logic            biu_d_ack_o,   // present next write datum
  input  logic [PLEN-1:0] biu_adri_i,
  output logic [PLEN-1:0] biu_adro_o,
  input  biu_size_e       biu_size_i,
  input  biu_type_e       biu_type_i,
  input  logic [2:0]      biu_prot_i,
  input  logic            biu_lock_i,
  input  logic            biu_we_i,
  input  logic [XLEN-1:0] biu_d_i,
  output logic [XLEN-1:0] biu_q_o,
  output logic            biu_ack_o,
  output logic            biu_err_o,

  // AHB-Lite master port
  output logic            hsel_o,
  output logic [PLEN-1:0] haddr_o,
  output logic [XLEN-1:0] hwdata_o,
  input  logic [XLEN-1:0] hrdata_i,
  output htrans_e         htrans_o,
  output ahb_ctrl_t       ctrl_o,        // hwrite, hsize, hburst, hprot, hmastlock
  input  logic            hready_i,
  input  hresp_e          hresp_i
);

  biu_cmd_t cmd;          // decoded request
  logic     ap_data_ena;  // beat in address phase

  //////////////////////////////////////////////////////////////////////
  // stage 0, request decode
  //////////////////////////////////////////////////////////////////////

  biu_req_decode req_decode_inst (
    .biu_size_i (biu_size_i),
    .biu_type_i (biu_type_i),
    .biu_prot_i (biu_prot_i),
    .biu_lock_i (biu_lock_i),
    .biu_we_i   (biu_we_i),
    .cmd_o      (cmd)
  );

  // stage 1, address phase and burst sequencing
  ahb_addr_phase #(.XLEN(XLEN), .PLEN(PLEN)) addr_phase_inst (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_adri_i    (biu_adri_i),
    .cmd_i         (cmd),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .hready_i      (hready_i),
    .hresp_i       (hresp_i),
    .hsel_o        (hsel_o),
    .haddr_o       (haddr_o),
    .htrans_o      (htrans_o),
    .ctrl_o        (ctrl_o),
    .data_ena_o    (ap_data_ena),
    .err_o         (biu_err_o)     // abort pulse straight to the core
  );

  // stage 2, data phase
  ahb_data_phase #(.XLEN(XLEN), .PLEN(PLEN)) data_phase_inst (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .hready_i   (hready_i),
    .data_ena_i (ap_data_ena),
    .haddr_i    (haddr_o),
    .biu_d_i    (biu_d_i),
    .biu_q_o    (biu_q_o),
    .biu_adro_o (biu_adro_o),
    .biu_ack_o  (biu_ack_o),
    .hrdata_i   (hrdata_i),
    .hwdata_o   (hwdata_o)
  );

endmodule

//--- test/tb_ahb_slave.sv
// 32 bit slave, 1024 words, byte lanes ignored; 0..2 wait states, ERROR when haddr[15:8] is E0
module tb_ahb_slave
  import biu_ahb_pkg::*;
(
  input  logic        HCLK,
  input  logic        HRESETn,
  input  logic        hsel_i,
  input  logic [31:0] haddr_i,
  input  htrans_e     htrans_i,
  input  logic        hwrite_i,
  input  logic [31:0] hwdata_i,
  output logic [31:0] hrdata_o,
  output logic        hready_o,
  output hresp_e      hresp_o
);

  logic [31:0] mem [0:1023];
  logic        dp_valid;    // a transfer sits in the data phase
  logic        dp_write;
  logic        dp_err;      // its address hit the error window
  logic        err_phase;   // second cycle of the error response
  logic [9:0]  dp_idx;      // word index of that transfer
  logic [1:0]  wait_cnt;    // wait states still to insert
  logic [31:0] lcg_state;
  logic [31:0] lcg_nxt;
  logic        new_xfer;

  // classic 32 bit LCG
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // fill pattern, every address bit counts
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = (32'(i) * 32'h9E37_79B1) ^ (32'(i) << 20) ^ 32'hC0DE_0000;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // responses
  ////////////////////////////////////////////////////////////////////

  assign hready_o = !dp_valid || (dp_err ? err_phase : (wait_cnt == 2'd0));
  assign hresp_o  = (dp_valid && dp_err) ? HRESP_ERROR : HRESP_OKAY;
  assign hrdata_o = (dp_valid && !dp_write) ? mem[dp_idx] : '0;

  assign lcg_nxt  = lcg_next(lcg_state);
  assign new_xfer = hsel_i && (htrans_i == HTRANS_NONSEQ || htrans_i == HTRANS_SEQ);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_valid  <= 1'b0;
      dp_write  <= 1'b0;
      dp_err    <= 1'b0;
      err_phase <= 1'b0;
      dp_idx    <= '0;
      wait_cnt  <= 2'd0;
      lcg_state <= 32'd85;             // seed
    end else if (hready_o) begin
      // data phase done, take the next address phase
      dp_valid  <= new_xfer;
      dp_write  <= hwrite_i;
      dp_idx    <= haddr_i[11:2];
      dp_err    <= new_xfer && (haddr_i[15:8] == 8'hE0);
      err_phase <= 1'b0;
      if (new_xfer) begin
        lcg_state <= lcg_nxt;
        wait_cnt  <= 2'((lcg_nxt >> 16) % 3);   // 0, 1 or 2
      end
    end else if (dp_err) begin
      err_phase <= 1'b1;               // ERROR with hready high next
    end else begin
      wait_cnt <= wait_cnt - 2'd1;
    end
  end

  // write lands when its data phase completes
  always @(posedge HCLK) begin
    if (HRESETn && hready_o && dp_valid && dp_write && !dp_err) begin
      mem[dp_idx] <= hwdata_i;
    end
  end

endmodule

//--- test/tb_biu_ahb_master.sv
// XLEN/PLEN 32 only; stimulus table below, shadow memory mirrors the slave after reset
module tb_biu_ahb_master
  import biu_ahb_pkg::*;
;

  localparam int PERIOD = 4;
  localparam int NROWS  = 16;
  localparam int LIMIT  = NROWS * 16 * 4 * PERIOD + 400;  // watchdog time

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    biu_size_e   size;
    biu_type_e   btype;
    logic [2:0]  prot;
    logic        lock;
    logic [31:0] seed;     // data seed for writes
    logic        err;      // slave answers ERROR
  } row_t;

  logic HCLK = 1'b0;
  logic HRESETn;
  logic biu_stb, biu_stb_ack, biu_d_ack, biu_ack, biu_err, biu_lock, biu_we;
  logic [31:0] biu_adri, biu_adro, biu_d, biu_q;
  biu_size_e   biu_size;
  biu_type_e   biu_type;
  logic [2:0]  biu_prot;
  logic        hsel, hready;
  logic [31:0] haddr, hwdata, hrdata;
  htrans_e     htrans;
  ahb_ctrl_t   ctrl;
  hresp_e      hresp;

  row_t        rows [NROWS];
  logic [31:0] shadow [0:1023];
  int          errors = 0;

  always #(PERIOD / 2) HCLK = ~HCLK;

  biu_ahb_master #(.XLEN(32), .PLEN(32)) biu_ahb_master_inst (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .biu_stb_i(biu_stb), .biu_stb_ack_o(biu_stb_ack), .biu_d_ack_o(biu_d_ack),
    .biu_adri_i(biu_adri), .biu_adro_o(biu_adro), .biu_size_i(biu_size),
    .biu_type_i(biu_type), .biu_prot_i(biu_prot), .biu_lock_i(biu_lock),
    .biu_we_i(biu_we), .biu_d_i(biu_d), .biu_q_o(biu_q), .biu_ack_o(biu_ack),
    .biu_err_o(biu_err), .hsel_o(hsel), .haddr_o(haddr), .hwdata_o(hwdata),
    .hrdata_i(hrdata), .htrans_o(htrans), .ctrl_o(ctrl), .hready_i(hready),
    .hresp_i(hresp)
  );

  tb_ahb_slave ahb_slave_inst (
    .HCLK(HCLK), .HRESETn(HRESETn), .hsel_i(hsel), .haddr_i(haddr),
    .htrans_i(htrans), .hwrite_i(ctrl.hwrite), .hwdata_i(hwdata),
    .hrdata_o(hrdata), .hready_o(hready), .hresp_o(hresp)
  );

  ////////////////////////////////////////////////////////////////////
  // expected values
  ////////////////////////////////////////////////////////////////////

  function automatic int beat_count(input biu_type_e t);
    case (t)
      BIU_WRAP4, BIU_INCR4:   return 4;
      BIU_WRAP8, BIU_INCR8:   return 8;
      BIU_WRAP16, BIU_INCR16: return 16;
      default:                return 1;   // SINGLE and INCR
    endcase
  endfunction

  // word step, wraps stay inside beats*4 byte block
  function automatic logic [31:0] beat_addr(input logic [31:0] start, input biu_type_e t,
                                            input int k);
    logic [31:0] blk;
    blk = 32'(beat_count(t) * 4) - 32'd1;
    if (t == BIU_WRAP4 || t == BIU_WRAP8 || t == BIU_WRAP16)
      return (start & ~blk) | ((start + 32'(4 * k)) & blk);
    return start + 32'(4 * k);
  endfunction

  function automatic logic [3:0] exp_hprot(input logic [2:0] p);
    return {p[2], 1'b0, p[1], p[0]};  // cacheable, bufferable off, privileged, data
  endfunction

  function automatic logic [31:0] datum(input logic [31:0] seed, input int k);
    return seed * 32'h0100_0001 + 32'(k) * 32'h0001_0101;
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////////////
  // one table row, sampled on the falling edge
  ////////////////////////////////////////////////////////////////////

  task automatic run_row(input int r);
    row_t        row;
    int          beats, n_addr, n_dack, n_ack, n_err;
    logic        busy, stb_seen, dack_seen;
    logic [31:0] exp_a;
    row      = rows[r];
    beats    = beat_count(row.btype);
    n_addr   = 0;
    n_dack   = 0;
    n_ack    = 0;
    n_err    = 0;
    busy     = 1'b1;
    biu_stb  = 1'b1;                  // held until acknowledged
    biu_we   = row.we;
    biu_adri = row.addr;
    biu_size = row.size;
    biu_type = row.btype;
    biu_prot = row.prot;
    biu_lock = row.lock;
    biu_d    = datum(row.seed, 0);
    while (busy) begin
      @(negedge HCLK);
      stb_seen  = biu_stb_ack;
      dack_seen = biu_d_ack;
      // slave selected exactly while a transfer is on the bus
      if (hsel != (htrans != HTRANS_IDLE))
        report_error($sformatf("row %0d hsel %b with htrans %s", r, hsel, htrans.name()));
      if (hready && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ)) begin
        exp_a = beat_addr(row.addr, row.btype, n_addr);
        if (haddr != exp_a)
          report_error($sformatf("row %0d beat %0d haddr %h, expected %h",
                                 r, n_addr, haddr, exp_a));
        if (htrans != ((n_addr == 0) ? HTRANS_NONSEQ : HTRANS_SEQ))
          report_error($sformatf("row %0d beat %0d wrong htrans %s",
                                 r, n_addr, htrans.name()));
        // AHB burst code shares the core numbering
        if (ctrl.hwrite != row.we || ctrl.hsize != row.size ||
            ctrl.hburst != hburst_e'(row.btype))
          report_error($sformatf("row %0d ctrl write/size/burst %b", r, ctrl));
        if (ctrl.hprot != exp_hprot(row.prot) || ctrl.hmastlock != row.lock)
          report_error($sformatf("row %0d hprot %b lock %b", r, ctrl.hprot, ctrl.hmastlock));
        n_addr++;
      end
      // bus idle from the error pulse on
      if ((n_err != 0 || biu_err) && htrans != HTRANS_IDLE)
        report_error($sformatf("row %0d htrans %s after error", r, htrans.name()));
      if (biu_ack && hresp == HRESP_OKAY) begin
        exp_a = beat_addr(row.addr, row.btype, n_ack);
        if (biu_adro != exp_a)
          report_error($sformatf("row %0d ack %0d adro %h, expected %h",
                                 r, n_ack, biu_adro, exp_a));
        if (row.we) begin
          if (hwdata != datum(row.seed, n_ack))
            report_error($sformatf("row %0d beat %0d hwdata %h", r, n_ack, hwdata));
          shadow[exp_a[11:2]] = datum(row.seed, n_ack);
        end else if (biu_q != shadow[exp_a[11:2]]) begin
          report_error($sformatf("row %0d beat %0d read %h, expected %h", r, n_ack, biu_q,
                                 shadow[exp_a[11:2]]));
        end
        n_ack++;
      end
      if (biu_err) n_err++;
      if (dack_seen) n_dack++;
      busy = row.err ? !(n_err != 0 && !biu_err) : (n_ack < beats);
      @(posedge HCLK);
      #1;
      if (stb_seen) biu_stb = 1'b0;
      if (dack_seen) biu_d = datum(row.seed, n_dack);  // next beat's datum
    end
    if (!row.err && (n_addr != beats || n_dack != beats || n_err != 0))
      report_error($sformatf("row %0d counts addr %0d dack %0d err %0d, beats %0d",
                             r, n_addr, n_dack, n_err, beats));
    if (row.err && n_err != 1)
      report_error($sformatf("row %0d error pulse lasted %0d cycles", r, n_err));
  endtask

  ////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////

  initial begin
    //          we    addr         size       type        prot  lock  seed        err
    rows[0]  = '{1'b1, 32'h0000_0100, BIU_WORD,  BIU_SINGLE, 3'd0, 1'b0, 32'h11, 1'b0};
    rows[1]  = '{1'b0, 32'h0000_0100, BIU_WORD,  BIU_SINGLE, 3'd1, 1'b0, 32'h00, 1'b0};
    rows[2]  = '{1'b1, 32'h0000_0104, BIU_BYTE,  BIU_SINGLE, 3'd2, 1'b1, 32'h22, 1'b0};
    rows[3]  = '{1'b0, 32'h0000_0104, BIU_BYTE,  BIU_SINGLE, 3'd3, 1'b1, 32'h00, 1'b0};
    rows[4]  = '{1'b1, 32'h0000_0108, BIU_HWORD, BIU_SINGLE, 3'd4, 1'b0, 32'h33, 1'b0};
    rows[5]  = '{1'b0, 32'h0000_0108, BIU_HWORD, BIU_SINGLE, 3'd5, 1'b0, 32'h00, 1'b0};
    rows[6]  = '{1'b1, 32'h0000_0200, BIU_WORD,  BIU_INCR4,  3'd6, 1'b1, 32'h44, 1'b0};
    rows[7]  = '{1'b0, 32'h0000_0200, BIU_WORD,  BIU_INCR4,  3'd7, 1'b1, 32'h00, 1'b0};
    rows[8]  = '{1'b1, 32'h0000_0300, BIU_WORD,  BIU_INCR8,  3'd3, 1'b0, 32'h55, 1'b0};
    rows[9]  = '{1'b0, 32'h0000_0300, BIU_WORD,  BIU_INCR16, 3'd1, 1'b0, 32'h00, 1'b0};
    rows[10] = '{1'b1, 32'h0000_0408, BIU_WORD,  BIU_WRAP4,  3'd3, 1'b0, 32'h66, 1'b0};
    rows[11] = '{1'b0, 32'h0000_0414, BIU_WORD,  BIU_WRAP8,  3'd3, 1'b0, 32'h00, 1'b0};
    rows[12] = '{1'b1, 32'h0000_0528, BIU_WORD,  BIU_WRAP16, 3'd3, 1'b1, 32'h77, 1'b0};
    rows[13] = '{1'b0, 32'h0000_051C, BIU_WORD,  BIU_WRAP16, 3'd3, 1'b0, 32'h00, 1'b0};
    rows[14] = '{1'b1, 32'h0000_E000, BIU_WORD,  BIU_INCR4,  3'd3, 1'b0, 32'h88, 1'b1};
    rows[15] = '{1'b0, 32'h0000_0200, BIU_WORD,  BIU_INCR,   3'd3, 1'b0, 32'h00, 1'b0};

    HRESETn  = 1'b0;
    biu_stb  = 1'b0;
    biu_adri = '0;
    biu_size = BIU_WORD;
    biu_type = BIU_SINGLE;
    biu_prot = 3'd0;
    biu_lock = 1'b0;
    biu_we   = 1'b0;
    biu_d    = '0;
    repeat (3) @(posedge HCLK);
    #1;
    HRESETn = 1'b1;
    for (int i = 0; i < 1024; i++) shadow[i] = ahb_slave_inst.mem[i];  // start image
    @(posedge HCLK);
    #1;
    // idle bus after reset, hprot data and privileged
    if (htrans != HTRANS_IDLE || hsel || biu_err || biu_ack || biu_d_ack ||
        ctrl.hprot != 4'b0011)
      report_error($sformatf("bus not idle after reset, htrans %s hprot %b",
                             htrans.name(), ctrl.hprot));
    for (int r = 0; r < NROWS; r++) run_row(r);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(LIMIT);
    $display("watchdog expired, the run hung waiting for the DUT");
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- build.f
source/biu_ahb_pkg.sv
source/biu_req_decode.sv
source/ahb_addr_phase.sv
source/ahb_data_phase.sv
source/biu_ahb_master.sv
test/tb_ahb_slave.sv
test/tb_biu_ahb_master.sv

//--- Bender.yml
package:
  name: biu_ahb_master

sources:
  - source/biu_ahb_pkg.sv
  - source/biu_req_decode.sv
  - source/ahb_addr_phase.sv
  - source/ahb_data_phase.sv
  - source/biu_ahb_master.sv
  - target: test
    files:
      - test/tb_ahb_slave.sv
      - test/tb_biu_ahb_master.sv
